// ==== ig.f ====
+incdir+.
ig_pix_pkg.sv
ig_grad_pkg.sv
img_fetch.sv
grad_calc.sv
grad_writeback.sv
ig.sv
ig_tb.sv

// ==== ig_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ig_cfg.svh"

module ig_tb;

    import ig_pix_pkg::*;
    import ig_grad_pkg::*;

    localparam int FRAME = `IG_ROWS * `IG_COLS;
    // reset, one read per pixel, last-row flush, pipeline slack, quiet tail
    localparam int RUN_CYCLES  = 4 + FRAME + `IG_COLS + 8 + 100;
    localparam int CYCLE_LIMIT = RUN_CYCLES + 4096;

    logic       clk;
    logic       reset;
    logic       img_rd;
    addr_t      img_addr;
    pix_t       img_di;
    logic       grad_wr;
    addr_t      grad_addr;
    grad_word_t grad_do;
    logic       done;

    // image memory model and its one-cycle read pipe
    pix_t       img_mem [FRAME];
    logic       rd_pending;
    addr_t      rd_pending_addr;

    int         rd_count;
    int         wr_count;
    int         cycle_count;
    logic       done_seen;
    grad_word_t exp_word;

    ig dut (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    // ------------------------------------------------------------------
    // error reporting
    // ------------------------------------------------------------------

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAIL %s expected %h got %h at %0t", sig, expected, actual, $time);
        abort_run();
    endtask

    task automatic report_failure(input string what);
        $display("%s at %0t", what, $time);
        abort_run();
    endtask

    // ------------------------------------------------------------------
    // image contents and reference gradients
    // ------------------------------------------------------------------

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic set_pixel(input int row, input int col, input pix_t value);
        img_mem[row * `IG_COLS + col] = value;
    endtask

    task automatic fill_image();
        logic [31:0] lfsr;
        pix_t        p;
        int          a;
        int          b;
        lfsr = 32'h6a57_b45d;
        for (a = 0; a < FRAME; a++) begin
            p = '0;
            for (b = 0; b < `IG_PIX_W; b++) begin
                lfsr = lfsr_next(lfsr);
                p = {p[`IG_PIX_W-2:0], lfsr[0]};
            end
            img_mem[a] = p;
        end
        // gx of +255 and -255
        set_pixel(0, 0, 8'd0);
        set_pixel(0, 1, 8'd255);
        set_pixel(1, 10, 8'd255);
        set_pixel(1, 11, 8'd0);
        // gy of +255 and -255
        set_pixel(5, 20, 8'd0);
        set_pixel(6, 20, 8'd255);
        set_pixel(10, 30, 8'd255);
        set_pixel(11, 30, 8'd0);
    endtask

    // right neighbour minus pixel, pixel below minus pixel, zero at the edges
    function automatic grad_word_t expected_word(input int a);
        int         r;
        int         c;
        int         p;
        int         gx;
        int         gy;
        grad_word_t w;
        r  = a / `IG_COLS;
        c  = a % `IG_COLS;
        p  = int'(img_mem[a]);
        gx = 0;
        gy = 0;
        if (c != `IG_COLS - 1) begin
            gx = int'(img_mem[a + 1]) - p;
        end
        if (r != `IG_ROWS - 1) begin
            gy = int'(img_mem[a + `IG_COLS]) - p;
        end
        w.gx = grad_comp_t'(gx);
        w.gy = grad_comp_t'(gy);
        return w;
    endfunction

    task automatic check_outputs_idle();
        assert (img_rd === 1'b0) else report_mismatch("img_rd", 0, img_rd);
        assert (grad_wr === 1'b0) else report_mismatch("grad_wr", 0, grad_wr);
        assert (done === 1'b0) else report_mismatch("done", 0, done);
    endtask

    // ------------------------------------------------------------------
    // memory model and monitors, all on the falling edge
    // ------------------------------------------------------------------

    always @(negedge clk) begin
        if (rd_pending) begin
            img_di = img_mem[rd_pending_addr];
        end
        rd_pending      = img_rd;
        rd_pending_addr = img_addr;
    end

    always @(negedge clk) begin
        if (!reset && img_rd === 1'b1) begin
            assert (rd_count < FRAME)
                else report_failure("image read issued after the whole frame was read");
            assert (img_addr === addr_t'(rd_count))
                else report_mismatch("img_addr", rd_count, img_addr);
            rd_count++;
        end
    end

    always @(negedge clk) begin
        if (!reset && grad_wr === 1'b1) begin
            assert (wr_count < FRAME)
                else report_failure("gradient write issued after the whole frame was written");
            assert (grad_addr === addr_t'(wr_count))
                else report_mismatch("grad_addr", wr_count, grad_addr);
            // edge rule, corner included
            if (wr_count % `IG_COLS == `IG_COLS - 1) begin
                assert (grad_do.gx === '0) else report_mismatch("grad_do.gx", 0, grad_do.gx);
            end
            if (wr_count / `IG_COLS == `IG_ROWS - 1) begin
                assert (grad_do.gy === '0) else report_mismatch("grad_do.gy", 0, grad_do.gy);
            end
            exp_word = expected_word(wr_count);
            assert (grad_do === exp_word) else report_mismatch("grad_do", exp_word, grad_do);
            wr_count++;
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            if (done_seen) begin
                assert (done === 1'b1) else report_failure("done dropped before reset");
                assert (img_rd === 1'b0) else report_failure("image read issued after done");
                assert (grad_wr === 1'b0) else report_failure("gradient write issued after done");
            end else if (done === 1'b1) begin
                assert (wr_count == FRAME)
                    else report_mismatch("write count at done", FRAME, wr_count);
                done_seen = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            report_failure($sformatf("timeout, done not seen within %0d cycles", CYCLE_LIMIT));
        end
    end

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------

    initial begin
        reset           = 1'b1;
        img_di          = '0;
        rd_pending      = 1'b0;
        rd_pending_addr = '0;
        rd_count        = 0;
        wr_count        = 0;
        cycle_count     = 0;
        done_seen       = 1'b0;
        fill_image();

        repeat (4) begin
            @(negedge clk);
            check_outputs_idle();
        end
        reset = 1'b0;
        // outputs just after release, still ahead of the first clock
        #1;
        check_outputs_idle();

        wait (done_seen);
        repeat (100) @(negedge clk);
        @(posedge clk);

        if (rd_count != FRAME) begin
            report_failure($sformatf("wrong read total, %0d reads", rd_count));
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== ig.sv ====
`timescale 1ns/10ps
`default_nettype none

module ig (
    input  logic                    clk,
    input  logic                    reset,
    output logic                    img_rd,
    output ig_pix_pkg::addr_t       img_addr,
    input  ig_pix_pkg::pix_t        img_di,
    output logic                    grad_wr,
    output ig_pix_pkg::addr_t       grad_addr,
    output ig_grad_pkg::grad_word_t grad_do,
    output logic                    done
);

    import ig_pix_pkg::*;
    import ig_grad_pkg::*;

    // raster pixel stream
    logic       pix_valid;
    pix_t       pix;

    // gradient beats in address order
    logic       beat_valid;
    grad_beat_t beat;

    // ------------------------------------------------------------------
    // pipeline: fetch, line buffer, write port
    // ------------------------------------------------------------------

    img_fetch u_img_fetch (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .pix_valid (pix_valid),
        .pix       (pix)
    );

    grad_calc u_grad_calc (
        .clk        (clk),
        .reset      (reset),
        .pix_valid  (pix_valid),
        .pix        (pix),
        .beat_valid (beat_valid),
        .beat       (beat)
    );

    grad_writeback u_grad_writeback (
        .clk        (clk),
        .reset      (reset),
        .beat_valid (beat_valid),
        .beat       (beat),
        .grad_wr    (grad_wr),
        .grad_addr  (grad_addr),
        .grad_do    (grad_do),
        .done       (done)
    );

endmodule

`default_nettype wire

// ==== grad_writeback.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ig_cfg.svh"

module grad_writeback (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    beat_valid,
    input  ig_grad_pkg::grad_beat_t beat,
    output logic                    grad_wr,
    output ig_pix_pkg::addr_t       grad_addr,
    output ig_grad_pkg::grad_word_t grad_do,
    output logic                    done
);

    import ig_pix_pkg::*;

    localparam int LAST_ADDR = `IG_ROWS * `IG_COLS - 1;

    // writes already issued to the gradient memory
    addr_t wr_count;

    // ------------------------------------------------------------------
    // write port and completion
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            grad_wr  <= 1'b0;
            wr_count <= '0;
            done     <= 1'b0;
        end else begin
            grad_wr <= beat_valid;
            if (grad_wr) begin
                wr_count <= wr_count + 1'b1;
                // sticky until the next reset
                if (wr_count == addr_t'(LAST_ADDR)) begin
                    done <= 1'b1;
                end
            end
        end
    end

    // address and data ride along with the strobe
    always_ff @(posedge clk) begin
        if (beat_valid) begin
            grad_addr <= beat.addr;
            grad_do   <= beat.word;
        end
    end

endmodule

`default_nettype wire

// ==== grad_calc.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ig_cfg.svh"

module grad_calc (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    pix_valid,
    input  ig_pix_pkg::pix_t        pix,
    output logic                    beat_valid,
    output ig_grad_pkg::grad_beat_t beat
);

    import ig_pix_pkg::*;
    import ig_grad_pkg::*;

    localparam int COL_W    = $clog2(`IG_COLS);
    localparam int ROW_W    = $clog2(`IG_ROWS);
    localparam int LAST_COL = `IG_COLS - 1;
    localparam int LAST_ROW = `IG_ROWS - 1;

    calc_state_t      state;
    logic [COL_W-1:0] col;
    logic [COL_W-1:0] col_next;
    logic [ROW_W-1:0] row;
    logic             last_col;
    logic             last_row;
    logic             step;
    logic             emit;

    // previous row, slot c is overwritten once column c of the new row lands
    pix_t             line_buf [`IG_COLS];
    // previous row pixel above the current column
    pix_t             above_q;
    pix_t             right_pix;

    addr_t            out_addr;
    grad_comp_t       gx;
    grad_comp_t       gy;

    // zero-extend both samples before subtracting
    function automatic grad_comp_t diff(input pix_t a, input pix_t b);
        grad_comp_t ea;
        grad_comp_t eb;
        ea = grad_comp_t'({2'b00, a});
        eb = grad_comp_t'({2'b00, b});
        return ea - eb;
    endfunction

    assign last_col  = (col == COL_W'(LAST_COL));
    assign last_row  = (row == ROW_W'(LAST_ROW));
    // wraps to column 0 on the last column
    assign col_next  = col + 1'b1;
    assign right_pix = line_buf[col_next];

    // column advances on every pixel, and on every cycle of the flush
    assign step = (pix_valid && (state == calc_fill || state == calc_run))
                  || (state == calc_flush);
    assign emit = (pix_valid && state == calc_run) || (state == calc_flush);

    // ------------------------------------------------------------------
    // sequencer
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= calc_fill;
            col   <= '0;
            row   <= '0;
        end else begin
            if (step) begin
                col <= col_next;
                if (last_col) begin
                    row <= row + 1'b1;
                end
            end
            case (state)
                calc_fill: begin
                    if (pix_valid && last_col) begin
                        state <= calc_run;
                    end
                end
                calc_run: begin
                    if (pix_valid && last_col && last_row) begin
                        state <= calc_flush;
                    end
                end
                calc_flush: begin
                    if (last_col) begin
                        state <= calc_finished;
                    end
                end
                default: begin
                    state <= calc_finished;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------
    // line buffer and differences
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (pix_valid) begin
            line_buf[col] <= pix;
        end
        // on the last column this picks up column 0 of the row just stored
        if (step) begin
            above_q <= right_pix;
        end
    end

    always_comb begin
        if (last_col) begin
            gx = '0;
        end else begin
            gx = diff(right_pix, above_q);
        end
        // last row has nothing below it
        if (state == calc_flush) begin
            gy = '0;
        end else begin
            gy = diff(pix, above_q);
        end
    end

    // ------------------------------------------------------------------
    // output beat
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            beat_valid <= 1'b0;
            out_addr   <= '0;
        end else begin
            beat_valid <= emit;
            if (emit) begin
                out_addr <= out_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            beat.addr    <= out_addr;
            beat.word.gx <= gx;
            beat.word.gy <= gy;
        end
    end

endmodule

`default_nettype wire

// ==== img_fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ig_cfg.svh"

module img_fetch (
    input  logic              clk,
    input  logic              reset,
    output logic              img_rd,
    output ig_pix_pkg::addr_t img_addr,
    input  ig_pix_pkg::pix_t  img_di,
    output logic              pix_valid,
    output ig_pix_pkg::pix_t  pix
);

    import ig_pix_pkg::*;

    localparam int LAST_ADDR = `IG_ROWS * `IG_COLS - 1;

    fetch_state_t state;

    // ------------------------------------------------------------------
    // read sequencer
    // ------------------------------------------------------------------

    // one read per cycle for the whole time we are in read
    assign img_rd = (state == fetch_read);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= fetch_idle;
            img_addr <= '0;
        end else begin
            case (state)
                fetch_idle: begin
                    state <= fetch_read;
                end
                fetch_read: begin
                    if (img_addr == addr_t'(LAST_ADDR)) begin
                        state <= fetch_finished;
                    end else begin
                        img_addr <= img_addr + 1'b1;
                    end
                end
                fetch_finished: begin
                    // frame fully requested, wait for reset
                    state <= fetch_finished;
                end
                default: begin
                    state <= fetch_idle;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------
    // return path
    // ------------------------------------------------------------------

    // memory answers one cycle after the request
    always_ff @(posedge clk) begin
        if (reset) begin
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= img_rd;
        end
    end

    // data is only meaningful alongside pix_valid
    assign pix = img_di;

endmodule

`default_nettype wire

// ==== ig_grad_pkg.sv ====
`default_nettype none

`include "ig_cfg.svh"

package ig_grad_pkg;

    // two extra bits so -255..+255 fits
    typedef logic signed [`IG_PIX_W+1:0] grad_comp_t;

    // memory word, gx in the upper half
    typedef struct packed {
        grad_comp_t gx;
        grad_comp_t gy;
    } grad_word_t;

    // one result on its way to the write port
    typedef struct packed {
        ig_pix_pkg::addr_t addr;
        grad_word_t        word;
    } grad_beat_t;

    // line buffer sequencer
    typedef enum logic [1:0] {
        calc_fill,
        calc_run,
        calc_flush,
        calc_finished
    } calc_state_t;

endpackage

`default_nettype wire

// ==== ig_pix_pkg.sv ====
`default_nettype none

`include "ig_cfg.svh"

package ig_pix_pkg;

    // unsigned greyscale sample
    typedef logic [`IG_PIX_W-1:0] pix_t;

    // linear raster address, shared by both memories
    typedef logic [`IG_ADDR_W-1:0] addr_t;

    // image read sequencer
    typedef enum logic [1:0] {
        fetch_idle,
        fetch_read,
        fetch_finished
    } fetch_state_t;

endpackage

`default_nettype wire

// ==== ig_cfg.svh ====
`ifndef IG_CFG_SVH
`define IG_CFG_SVH

// ----------------------------------------------------------------------
// frame geometry
// ----------------------------------------------------------------------

// pixels per row
`define IG_COLS 256

// rows per frame, power of two
`define IG_ROWS 256

// ----------------------------------------------------------------------
// sample and bus widths
// ----------------------------------------------------------------------

// greyscale sample
`define IG_PIX_W 8

// must cover IG_ROWS * IG_COLS
`define IG_ADDR_W 16

`endif
